// ==== tl_sw_macros.svh ====
`ifndef TL_SW_MACROS_SVH
`define TL_SW_MACROS_SVH

// ----------------------------------------
// Traffic light
// ----------------------------------------
// Phase length in clock cycles
`define TL_DUR_W        8
`define TL_RED_DEF      8'd5
`define TL_GREEN_DEF    8'd5
`define TL_YELLOW_DEF   8'd2

// ----------------------------------------
// Stopwatch
// ----------------------------------------
// Clock cycles per stopwatch second
`define SW_PRESCALE_W   16
`define SW_PRESCALE_DEF 16'd4

// ----------------------------------------
// AXI4-Lite register map
// ----------------------------------------
`define AXI_ADDR_W      5
`define AXI_DATA_W      32
`define CSR_ADDR_DUR      5'h00
`define CSR_ADDR_PRESCALE 5'h04
`define CSR_ADDR_CTRL     5'h08
`define CSR_ADDR_TIME     5'h0C
`define CSR_ADDR_STATUS   5'h10

`endif

// ==== light_pkg.sv ====
package light_pkg;

    // Sequencer phases, listed in firing order
    typedef enum logic [1:0] {
        RED    = 2'd0,
        GREEN  = 2'd1,
        YELLOW = 2'd2
    } light_phase_t;

    // One-hot lamp drive
    // Red on top, green at bit 0
    typedef enum logic [2:0] {
        LAMP_RED    = 3'b100,
        LAMP_YELLOW = 3'b010,
        LAMP_GREEN  = 3'b001
    } lamp_t;

endpackage

// ==== csr_pkg.sv ====
`include "tl_sw_macros.svh"

package csr_pkg;

    // AXI response codes actually used by the slave
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    // Word index, address bits 4..2
    typedef enum logic [2:0] {
        IDX_DUR      = 3'(`CSR_ADDR_DUR >> 2),
        IDX_PRESCALE = 3'(`CSR_ADDR_PRESCALE >> 2),
        IDX_CTRL     = 3'(`CSR_ADDR_CTRL >> 2),
        IDX_TIME     = 3'(`CSR_ADDR_TIME >> 2),
        IDX_STATUS   = 3'(`CSR_ADDR_STATUS >> 2)
    } csr_index_t;

    // Byte offset bits are ignored
    function automatic csr_index_t addr_index(input logic [`AXI_ADDR_W-1:0] addr);
        return csr_index_t'(addr[4:2]);
    endfunction

    // Indices past STATUS are unmapped
    function automatic logic index_valid(input csr_index_t idx);
        return idx <= IDX_STATUS;
    endfunction

endpackage

// ==== traffic_light.sv ====
`timescale 1ns/1ps
`include "tl_sw_macros.svh"

module traffic_light import light_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`TL_DUR_W-1:0] red_dur,
    input  logic [`TL_DUR_W-1:0] green_dur,
    input  logic [`TL_DUR_W-1:0] yellow_dur,
    output lamp_t                lamp
);

    light_phase_t         phase;
    light_phase_t         next_phase;
    logic [`TL_DUR_W-1:0] cnt;
    logic [`TL_DUR_W-1:0] next_dur;
    logic [`TL_DUR_W-1:0] cur_left;
    logic                 phase_end;

    // Programmed zero still gives one cycle
    function automatic logic [`TL_DUR_W-1:0] eff_dur(input logic [`TL_DUR_W-1:0] d);
        return (d == '0) ? `TL_DUR_W'(1) : d;
    endfunction

    // ----------------------------------------
    // Next phase and its length
    // ----------------------------------------
    always_comb begin
        case (phase)
            RED: begin
                next_phase = GREEN;
                next_dur   = green_dur;
            end
            GREEN: begin
                next_phase = YELLOW;
                next_dur   = yellow_dur;
            end
            default: begin
                next_phase = RED;
                next_dur   = red_dur;
            end
        endcase
    end

    // Zero count only in the first cycle out of reset
    // Red length then comes straight from the register
    assign cur_left  = (cnt == '0) ? eff_dur(red_dur) : cnt;
    assign phase_end = (cur_left == `TL_DUR_W'(1));

    // Count holds cycles left in the phase, this one included
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= RED;
            cnt   <= '0;
        end else if (phase_end) begin
            phase <= next_phase;
            // Length latched here, later writes wait for the next entry
            cnt   <= eff_dur(next_dur);
        end else begin
            cnt <= cur_left - `TL_DUR_W'(1);
        end
    end

    // ----------------------------------------
    // Lamp decode
    // ----------------------------------------
    always_comb begin
        case (phase)
            GREEN:   lamp = LAMP_GREEN;
            YELLOW:  lamp = LAMP_YELLOW;
            default: lamp = LAMP_RED;
        endcase
    end

endmodule

// ==== stopwatch.sv ====
`timescale 1ns/1ps
`include "tl_sw_macros.svh"

module stopwatch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`SW_PRESCALE_W-1:0] prescale,
    input  logic                      run_toggle,
    input  logic                      clear,
    input  logic                      load,
    input  logic [4:0]                preset_hour,
    input  logic [5:0]                preset_min,
    input  logic [5:0]                preset_sec,
    output logic [4:0]                hour,
    output logic [5:0]                min,
    output logic [5:0]                sec,
    output logic                      running
);

    logic [`SW_PRESCALE_W-1:0] pre_cnt;
    logic [`SW_PRESCALE_W-1:0] pre_last;
    logic                      restart;
    logic                      tick;
    logic [4:0]                load_hour;
    logic [5:0]                load_min;
    logic [5:0]                load_sec;

    // ----------------------------------------
    // Prescaler
    // ----------------------------------------
    // Prescale of zero behaves as one
    assign pre_last = (prescale == '0) ? '0 : prescale - 1'b1;
    assign restart  = clear | load | run_toggle;
    // >= covers a prescale lowered below the running count
    assign tick     = running && !restart && (pre_cnt >= pre_last);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            pre_cnt <= '0;
        end else begin
            // Clear and load win over a toggle in the same cycle
            if (run_toggle && !clear && !load)
                running <= ~running;
            if (restart || !running || tick)
                pre_cnt <= '0;
            else
                pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // Out-of-range presets saturate
    assign load_hour = (preset_hour > 5'd23) ? 5'd23 : preset_hour;
    assign load_min  = (preset_min > 6'd59) ? 6'd59 : preset_min;
    assign load_sec  = (preset_sec > 6'd59) ? 6'd59 : preset_sec;

    // ----------------------------------------
    // Time of day counters
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hour <= '0;
            min  <= '0;
            sec  <= '0;
        end else if (clear) begin
            hour <= '0;
            min  <= '0;
            sec  <= '0;
        end else if (load) begin
            hour <= load_hour;
            min  <= load_min;
            sec  <= load_sec;
        end else if (tick) begin
            // Seconds carry into minutes, minutes into hours
            if (sec == 6'd59) begin
                sec <= '0;
                if (min == 6'd59) begin
                    min  <= '0;
                    hour <= (hour == 5'd23) ? 5'd0 : hour + 1'b1;
                end else begin
                    min <= min + 1'b1;
                end
            end else begin
                sec <= sec + 1'b1;
            end
        end
    end

endmodule

// ==== tl_sw_csr.sv ====
`timescale 1ns/1ps
`include "tl_sw_macros.svh"

module tl_sw_csr import csr_pkg::*, light_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`AXI_ADDR_W-1:0]    awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`AXI_DATA_W-1:0]    wdata,
    input  logic                      wvalid,
    output logic                      wready,
    output axi_resp_t                 bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`AXI_ADDR_W-1:0]    araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`AXI_DATA_W-1:0]    rdata,
    output axi_resp_t                 rresp,
    output logic                      rvalid,
    input  logic                      rready,
    output logic [`TL_DUR_W-1:0]      red_dur,
    output logic [`TL_DUR_W-1:0]      green_dur,
    output logic [`TL_DUR_W-1:0]      yellow_dur,
    output logic [`SW_PRESCALE_W-1:0] prescale,
    output logic                      run_toggle,
    output logic                      clear,
    output logic                      load,
    output logic [4:0]                preset_hour,
    output logic [5:0]                preset_min,
    output logic [5:0]                preset_sec,
    input  lamp_t                     lamp,
    input  logic [4:0]                hour,
    input  logic [5:0]                min,
    input  logic [5:0]                sec,
    input  logic                      running
);

    logic                   wr_fire;
    logic                   rd_fire;
    logic                   wr_ok;
    logic                   rd_ok;
    logic                   wr_ctrl;
    csr_index_t             wr_idx;
    csr_index_t             rd_idx;
    logic [`AXI_DATA_W-1:0] rd_word;

    assign wr_fire = awvalid && awready && wvalid && wready;
    assign rd_fire = arvalid && arready;
    assign wr_idx  = addr_index(awaddr);
    assign rd_idx  = addr_index(araddr);
    // STATUS is read-only
    assign wr_ok   = index_valid(wr_idx) && (wr_idx != IDX_STATUS);
    assign rd_ok   = index_valid(rd_idx);
    assign wr_ctrl = wr_fire && (wr_idx == IDX_CTRL);

    // ----------------------------------------
    // Write channel
    // ----------------------------------------
    // Address and data taken in the same cycle, one at a time
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !bvalid && !awready;
            wready  <= awvalid && wvalid && !bvalid && !awready;
            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire)
            bresp <= wr_ok ? OKAY : SLVERR;
    end

    // Configuration registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            red_dur     <= `TL_RED_DEF;
            green_dur   <= `TL_GREEN_DEF;
            yellow_dur  <= `TL_YELLOW_DEF;
            prescale    <= `SW_PRESCALE_DEF;
            preset_hour <= '0;
            preset_min  <= '0;
            preset_sec  <= '0;
        end else if (wr_fire) begin
            case (wr_idx)
                IDX_DUR: begin
                    red_dur    <= wdata[7:0];
                    green_dur  <= wdata[15:8];
                    yellow_dur <= wdata[23:16];
                end
                IDX_PRESCALE: prescale <= wdata[`SW_PRESCALE_W-1:0];
                IDX_TIME: begin
                    preset_hour <= wdata[20:16];
                    preset_min  <= wdata[13:8];
                    preset_sec  <= wdata[5:0];
                end
                default: ;
            endcase
        end
    end

    // CTRL bits become single-cycle strobes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_toggle <= 1'b0;
            clear      <= 1'b0;
            load       <= 1'b0;
        end else begin
            run_toggle <= wr_ctrl && wdata[0];
            clear      <= wr_ctrl && wdata[1];
            load       <= wr_ctrl && wdata[2];
        end
    end

    // ----------------------------------------
    // Read channel
    // ----------------------------------------
    always_comb begin
        case (rd_idx)
            IDX_DUR:      rd_word = {8'h00, yellow_dur, green_dur, red_dur};
            IDX_PRESCALE: rd_word = `AXI_DATA_W'(prescale);
            IDX_TIME:     rd_word = {11'd0, hour, 2'b00, min, 2'b00, sec};
            IDX_STATUS:   rd_word = {27'd0, running, 1'b0, lamp};
            // CTRL strobes and unmapped words read as zero
            default:      rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !rvalid && !arready;
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // Data held until rready
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_ok ? OKAY : SLVERR;
        end
    end

endmodule

// ==== tl_sw_top.sv ====
`timescale 1ns/1ps
`include "tl_sw_macros.svh"

module tl_sw_top import csr_pkg::*, light_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`AXI_DATA_W-1:0] wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output axi_resp_t              bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [`AXI_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [`AXI_DATA_W-1:0] rdata,
    output axi_resp_t              rresp,
    output logic                   rvalid,
    input  logic                   rready,
    output lamp_t                  lamp
);

    // ----------------------------------------
    // Register block to engines
    // ----------------------------------------
    logic [`TL_DUR_W-1:0]      red_dur;
    logic [`TL_DUR_W-1:0]      green_dur;
    logic [`TL_DUR_W-1:0]      yellow_dur;
    logic [`SW_PRESCALE_W-1:0] prescale;
    logic                      run_toggle;
    logic                      clear;
    logic                      load;
    logic [4:0]                preset_hour;
    logic [5:0]                preset_min;
    logic [5:0]                preset_sec;

    // Stopwatch back to readback
    logic [4:0]                hour;
    logic [5:0]                min;
    logic [5:0]                sec;
    logic                      running;

    tl_sw_csr u_csr (
        .clk         (clk),
        .rst         (rst),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .red_dur     (red_dur),
        .green_dur   (green_dur),
        .yellow_dur  (yellow_dur),
        .prescale    (prescale),
        .run_toggle  (run_toggle),
        .clear       (clear),
        .load        (load),
        .preset_hour (preset_hour),
        .preset_min  (preset_min),
        .preset_sec  (preset_sec),
        .lamp        (lamp),
        .hour        (hour),
        .min         (min),
        .sec         (sec),
        .running     (running)
    );

    // Lamp also drives the pins directly
    traffic_light u_light (
        .clk        (clk),
        .rst        (rst),
        .red_dur    (red_dur),
        .green_dur  (green_dur),
        .yellow_dur (yellow_dur),
        .lamp       (lamp)
    );

    stopwatch u_watch (
        .clk         (clk),
        .rst         (rst),
        .prescale    (prescale),
        .run_toggle  (run_toggle),
        .clear       (clear),
        .load        (load),
        .preset_hour (preset_hour),
        .preset_min  (preset_min),
        .preset_sec  (preset_sec),
        .hour        (hour),
        .min         (min),
        .sec         (sec),
        .running     (running)
    );

endmodule

// ==== tl_sw_checker.sv ====
`timescale 1ns/1ps
`include "tl_sw_macros.svh"

module tl_sw_checker import light_pkg::*, csr_pkg::*; (
    input logic                   clk,
    input logic                   rst,
    input lamp_t                  lamp,
    input logic                   awvalid,
    input logic                   awready,
    input logic                   wvalid,
    input logic                   wready,
    input logic                   arvalid,
    input logic                   arready,
    input logic                   bvalid,
    input logic                   bready,
    input axi_resp_t              bresp,
    input logic                   rvalid,
    input logic                   rready,
    input logic [`AXI_DATA_W-1:0] rdata,
    input axi_resp_t              rresp
);

    // ----------------------------------------
    // Lamp sequence
    // ----------------------------------------
    property lamp_order;
        @(posedge clk) disable iff (rst)
        (lamp != $past(lamp)) |->
            ((lamp == LAMP_GREEN  && $past(lamp) == LAMP_RED)   ||
             (lamp == LAMP_YELLOW && $past(lamp) == LAMP_GREEN) ||
             (lamp == LAMP_RED    && $past(lamp) == LAMP_YELLOW));
    endproperty

    lamp_onehot_a: assert property (@(posedge clk) disable iff (rst) $onehot(lamp))
        else $error("lamp is not one-hot");
    lamp_order_a: assert property (lamp_order)
        else $error("lamp skipped a phase");

    // ----------------------------------------
    // AXI handshakes
    // ----------------------------------------
    // Accepted write or read answers on the next edge
    wr_resp_a: assert property (@(posedge clk) disable iff (rst)
        (awvalid && awready && wvalid && wready) |=> bvalid)
        else $error("no write response after the write handshake");
    rd_resp_a: assert property (@(posedge clk) disable iff (rst)
        (arvalid && arready) |=> rvalid)
        else $error("no read response after the read handshake");

    // Responses hold while the host stalls
    b_hold_a: assert property (@(posedge clk) disable iff (rst)
        (bvalid && !bready) |=> (bvalid && $stable(bresp)))
        else $error("write response dropped or changed under back-pressure");
    r_hold_a: assert property (@(posedge clk) disable iff (rst)
        (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
        else $error("read response dropped or changed under back-pressure");

    // Idle handshakes while in reset
    reset_idle_a: assert property (@(posedge clk)
        rst |-> (!awready && !wready && !arready && !bvalid && !rvalid))
        else $error("handshake active during reset");

endmodule

bind tl_sw_top tl_sw_checker chk (
    .clk     (clk),
    .rst     (rst),
    .lamp    (lamp),
    .awvalid (awvalid),
    .awready (awready),
    .wvalid  (wvalid),
    .wready  (wready),
    .arvalid (arvalid),
    .arready (arready),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp)
);

// ==== tl_sw_tb.sv ====
`timescale 1ns/1ps
`include "tl_sw_macros.svh"

module tl_sw_tb import light_pkg::*, csr_pkg::*; ();

    // Three light runs of two full sequences at the 20-cycle maximum
    // plus about forty AXI transactions of five cycles each
    // Margin of four on top
    localparam int LIGHT_CYCLES = 3 * 2 * (3 * 20);
    localparam int AXI_CYCLES   = 40 * 5;
    localparam int WATCHDOG_NS  = 4 * (LIGHT_CYCLES + AXI_CYCLES) * 10;

    logic                   clk;
    logic                   rst;
    logic [`AXI_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [`AXI_DATA_W-1:0] wdata;
    logic                   wvalid;
    logic                   wready;
    axi_resp_t              bresp;
    logic                   bvalid;
    logic                   bready;
    logic [`AXI_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   arready;
    logic [`AXI_DATA_W-1:0] rdata;
    axi_resp_t              rresp;
    logic                   rvalid;
    logic                   rready;
    lamp_t                  lamp;
    integer                 seed;

    tl_sw_top dut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ----------------------------------------
    // Failure reporting
    // ----------------------------------------
    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("ERR at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_true(input logic cond, input string why);
        assert (cond)
        else begin
            $display("%s", why);
            abort_run();
        end
    endtask

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        abort_run();
    end

    // ----------------------------------------
    // AXI4-Lite host tasks entered on a falling edge
    // ----------------------------------------
    task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                             input int hold, output axi_resp_t resp);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (hold == 0);
        // awready and wready show one cycle before the handshake edge
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        resp = bresp;
        repeat (hold) @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
    endtask

    task automatic axi_read(input logic [4:0] addr, input int hold,
                            output logic [31:0] data, output axi_resp_t resp);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (hold == 0);
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        repeat (hold) @(negedge clk);
        rready = 1'b1;
        @(negedge clk);
    endtask

    // Mapped register expects OKAY
    task automatic write_ok(input logic [4:0] addr, input logic [31:0] data, input int hold);
        axi_resp_t resp;
        axi_write(addr, data, hold, resp);
        check_val("bresp", 32'(resp), 32'(OKAY));
    endtask

    task automatic read_ok(input logic [4:0] addr, input int hold, output logic [31:0] data);
        axi_resp_t resp;
        axi_read(addr, hold, data, resp);
        check_val("rresp", 32'(resp), 32'(OKAY));
    endtask

    // ----------------------------------------
    // Reference values
    // ----------------------------------------
    // Zero duration lasts one cycle
    function automatic int expected_len(input logic [7:0] d);
        return (d == 8'd0) ? 1 : int'(d);
    endfunction

    function automatic logic [31:0] time_word(input int h, input int m, input int s);
        return {11'd0, 5'(h), 2'b00, 6'(m), 2'b00, 6'(s)};
    endfunction

    function automatic logic [7:0] rand_dur();
        int v;
        v = $random(seed);
        return 8'(1 + ($unsigned(v) % 20));
    endfunction

    // Lengths of one full sequence from a fresh green entry
    task automatic measure_sequence(output int g, output int y, output int r);
        while (lamp != LAMP_RED) @(negedge clk);
        while (lamp == LAMP_RED) @(negedge clk);
        g = 0;
        y = 0;
        r = 0;
        while (lamp == LAMP_GREEN) begin
            g++;
            @(negedge clk);
        end
        while (lamp == LAMP_YELLOW) begin
            y++;
            @(negedge clk);
        end
        while (lamp == LAMP_RED) begin
            r++;
            @(negedge clk);
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        int          g;
        int          y;
        int          r;
        int          polls;
        logic [7:0]  rd;
        logic [7:0]  gd;
        logic [7:0]  yd;
        logic [31:0] data;
        logic [31:0] t1;
        logic [31:0] t2;
        logic [31:0] preset;
        axi_resp_t   resp;

        seed    = 42364;
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // Default phase lengths
        measure_sequence(g, y, r);
        check_val("green length", g, expected_len(`TL_GREEN_DEF));
        check_val("yellow length", y, expected_len(`TL_YELLOW_DEF));
        check_val("red length", r, expected_len(`TL_RED_DEF));

        // Random durations with a zero green in the second round
        for (int round = 0; round < 2; round++) begin
            rd = rand_dur();
            gd = (round == 1) ? 8'd0 : rand_dur();
            yd = rand_dur();
            // First write stalls the response for four cycles
            write_ok(`CSR_ADDR_DUR, {8'h00, yd, gd, rd}, (round == 0) ? 4 : 0);
            read_ok(`CSR_ADDR_DUR, 0, data);
            check_val("DUR", data, {8'h00, yd, gd, rd});
            measure_sequence(g, y, r);
            check_val("green length", g, expected_len(gd));
            check_val("yellow length", y, expected_len(yd));
            check_val("red length", r, expected_len(rd));
        end

        // Stopwatch run, stop, clear
        write_ok(`CSR_ADDR_PRESCALE, 32'd1, 0);
        write_ok(`CSR_ADDR_CTRL, 32'h1, 0);
        read_ok(`CSR_ADDR_STATUS, 0, data);
        check_val("STATUS.running", 32'(data[4]), 32'd1);
        repeat (12) @(negedge clk);
        write_ok(`CSR_ADDR_CTRL, 32'h1, 0);
        read_ok(`CSR_ADDR_TIME, 0, t1);
        read_ok(`CSR_ADDR_TIME, 0, t2);
        check_val("TIME after stop", t2, t1);
        check_true(t1 != 32'd0, "Stopwatch did not count while running");
        read_ok(`CSR_ADDR_STATUS, 0, data);
        check_val("STATUS.running", 32'(data[4]), 32'd0);
        write_ok(`CSR_ADDR_CTRL, 32'h2, 0);
        read_ok(`CSR_ADDR_TIME, 0, data);
        check_val("TIME after clear", data, 32'd0);

        // Preset 23:59:59 and wrap
        preset = time_word(23, 59, 59);
        write_ok(`CSR_ADDR_PRESCALE, 32'd3, 0);
        write_ok(`CSR_ADDR_TIME, preset, 0);
        write_ok(`CSR_ADDR_CTRL, 32'h4, 0);
        read_ok(`CSR_ADDR_TIME, 0, data);
        check_val("TIME after preset", data, preset);
        write_ok(`CSR_ADDR_CTRL, 32'h1, 0);
        polls = 0;
        while (data == preset && polls < 20) begin
            read_ok(`CSR_ADDR_TIME, 0, data);
            polls++;
        end
        check_true(data != preset, "Stopwatch never left the preset time");
        check_val("TIME after wrap", data, time_word(0, 0, 0));
        write_ok(`CSR_ADDR_CTRL, 32'h1, 0);

        // Unmapped read under a held response
        axi_read(5'h14, 4, data, resp);
        check_val("rresp unmapped", 32'(resp), 32'(SLVERR));
        check_val("rdata unmapped", data, 32'd0);
        // STATUS is read-only
        axi_write(`CSR_ADDR_STATUS, 32'hFFFF_FFFF, 0, resp);
        check_val("bresp STATUS", 32'(resp), 32'(SLVERR));
        read_ok(`CSR_ADDR_PRESCALE, 3, data);
        check_val("PRESCALE", data, 32'd3);
        read_ok(`CSR_ADDR_DUR, 0, data);
        check_val("DUR", data, {8'h00, yd, gd, rd});

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
light_pkg.sv
csr_pkg.sv
traffic_light.sv
stopwatch.sv
tl_sw_csr.sv
tl_sw_top.sv
tl_sw_checker.sv
tl_sw_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tl_sw_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
